/* Bender.yml */
package:
  name: controller_standby_i3c

sources:
  # Design, in compile order
  - common/i3c_rx_pkg.sv
  - bus_monitor/bus_monitor.sv
  - verilog/bus_rx_flow.sv
  - verilog/target_rx_fsm.sv
  - verilog/descriptor_rx.sv
  - verilog/controller_standby_i3c.sv
  # Bound checks and testbench
  - target: test
    files:
      - verification/controller_standby_i3c_assert.sv
      - verification/tb_controller_standby_i3c.sv

/* all.f */
common/i3c_rx_pkg.sv
bus_monitor/bus_monitor.sv
verilog/bus_rx_flow.sv
verilog/target_rx_fsm.sv
verilog/descriptor_rx.sv
verilog/controller_standby_i3c.sv
verification/controller_standby_i3c_assert.sv
verification/tb_controller_standby_i3c.sv

/* bus_monitor/bus_monitor.sv */
// Bus monitor, synchronizes SCL and SDA and flags edges and START, Sr and STOP
`timescale 1ns/10ps

module bus_monitor #(
  parameter int unsigned SyncStages = 2
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic enable_i,
  input  logic scl_i,
  input  logic sda_i,
  output logic scl_posedge_o,
  output logic scl_negedge_o,
  output logic sda_o,
  output logic start_o,
  output logic rstart_o,
  output logic stop_o
);

  logic [SyncStages-1:0] scl_sync;
  logic [SyncStages-1:0] sda_sync;
  logic scl_q;
  logic sda_q;
  logic scl_prev;
  logic sda_prev;
  logic scl_high;
  logic sda_fall;
  logic sda_rise;
  logic bus_busy;

  // Idle bus is high, so the chain resets to ones
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync <= '1;
      sda_sync <= '1;
      scl_prev <= 1'b1;
      sda_prev <= 1'b1;
    end else begin
      scl_sync[0] <= scl_i;
      sda_sync[0] <= sda_i;
      for (int i = 1; i < SyncStages; i++) begin
        scl_sync[i] <= scl_sync[i-1];
        sda_sync[i] <= sda_sync[i-1];
      end
      scl_prev <= scl_q;
      sda_prev <= sda_q;
    end
  end

  assign scl_q = scl_sync[SyncStages-1];
  assign sda_q = sda_sync[SyncStages-1];

  assign scl_high = scl_q & scl_prev;
  assign sda_fall = sda_prev & ~sda_q;
  assign sda_rise = ~sda_prev & sda_q;

  // Lines up with the registered strobes below
  assign sda_o = sda_prev;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_posedge_o <= 1'b0;
      scl_negedge_o <= 1'b0;
      start_o       <= 1'b0;
      rstart_o      <= 1'b0;
      stop_o        <= 1'b0;
      bus_busy      <= 1'b0;
    end else if (!enable_i) begin
      scl_posedge_o <= 1'b0;
      scl_negedge_o <= 1'b0;
      start_o       <= 1'b0;
      rstart_o      <= 1'b0;
      stop_o        <= 1'b0;
      bus_busy      <= 1'b0;
    end else begin
      scl_posedge_o <= scl_q & ~scl_prev;
      scl_negedge_o <= ~scl_q & scl_prev;
      start_o       <= scl_high & sda_fall & ~bus_busy;
      rstart_o      <= scl_high & sda_fall & bus_busy;
      stop_o        <= scl_high & sda_rise;
      // Busy from START until STOP separates Sr from START
      if (scl_high && sda_fall) begin
        bus_busy <= 1'b1;
      end else if (scl_high && sda_rise) begin
        bus_busy <= 1'b0;
      end
    end
  end

endmodule

/* common/i3c_rx_pkg.sv */
// Shared widths and types for the I3C standby receive path
package i3c_rx_pkg;

  // Bus and queue widths
  localparam int unsigned AddrWidth = 7;
  localparam int unsigned ByteWidth = 8;
  localparam int unsigned DescWidth = 32;
  localparam int unsigned CountWidth = 16;

  // Address field and RnW bit of the first byte after a START
  typedef struct packed {
    logic [AddrWidth-1:0] addr;
    logic                 rnw;
  } addr_fields_t;

  // Raw view goes to the descriptor, field view drives matching
  typedef union packed {
    logic [ByteWidth-1:0] raw;
    addr_fields_t         fields;
  } addr_byte_u;

  typedef enum logic [2:0] {
    Idle,
    Addr,
    AddrAck,
    Data,
    TBit,
    Ignore
  } rx_state_e;

endpackage

/* verification/controller_standby_i3c_assert.sv */
// Bound checks on the strobes and the SDA drive of the I3C standby receive path
`timescale 1ns/10ps

module controller_standby_i3c_assert (
  input logic                  clk_i,
  input logic                  rst_ni,
  input logic                  bus_start_i,
  input logic                  bus_stop_i,
  input logic                  rx_queue_full_i,
  input logic                  rx_queue_wvalid_i,
  input logic                  rx_desc_queue_wvalid_i,
  input logic                  ctrl_sda_i,
  input i3c_rx_pkg::rx_state_e fsm_state_i
);
  import i3c_rx_pkg::*;

  int unsigned fail_count = 0;

  start_stop_apart: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !(bus_start_i && bus_stop_i))
    else begin
      fail_count++;
      $error("START and STOP strobes high in the same cycle");
    end

  data_write_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_queue_wvalid_i |=> !rx_queue_wvalid_i)
    else begin
      fail_count++;
      $error("RX queue write strobe longer than one cycle");
    end

  desc_write_single: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_desc_queue_wvalid_i |=> !rx_desc_queue_wvalid_i)
    else begin
      fail_count++;
      $error("Descriptor write strobe longer than one cycle");
    end

  no_write_when_full: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_queue_wvalid_i |-> !rx_queue_full_i)
    else begin
      fail_count++;
      $error("RX queue written while full");
    end

  // Only the ACK may pull the line low
  sda_released: assert property (@(posedge clk_i) disable iff (!rst_ni)
    (fsm_state_i != AddrAck) |-> ctrl_sda_i)
    else begin
      fail_count++;
      $error("SDA driven low outside the ACK state");
    end

endmodule

bind controller_standby_i3c controller_standby_i3c_assert i_assert (
  .clk_i,
  .rst_ni,
  .bus_start_i           (bus_start_o),
  .bus_stop_i            (bus_stop_o),
  .rx_queue_full_i       (rx_queue_full_i),
  .rx_queue_wvalid_i     (rx_queue_wvalid_o),
  .rx_desc_queue_wvalid_i(rx_desc_queue_wvalid_o),
  .ctrl_sda_i            (ctrl_sda_o),
  .fsm_state_i           (xtarget_rx_fsm.state_q)
);

/* verification/tb_controller_standby_i3c.sv */
// Testbench for the I3C standby receive path, random writes checked against a queue model
`timescale 1ns/10ps

module tb_controller_standby_i3c;
  import i3c_rx_pkg::*;

  localparam int unsigned ClkPeriod = 20;
  localparam int unsigned HalfScl = 8;
  localparam int unsigned BitCycles = 2 * HalfScl;
  localparam int unsigned NumXfers = 20;
  localparam int unsigned MaxBytes = 6;
  // Address byte on top of the data, 9 bits per byte, twice over
  localparam int unsigned WatchdogNs =
    2 * NumXfers * (MaxBytes + 1) * 9 * BitCycles * ClkPeriod;
  localparam int unsigned EvStart = 1;
  localparam int unsigned EvRstart = 2;
  localparam int unsigned EvStop = 3;

  logic clk_i;
  logic rst_ni;
  logic standby_en;
  logic scl;
  logic sda_drv;
  logic sda_dut;
  logic sda_bus;
  logic [AddrWidth-1:0] sta_addr;
  logic [AddrWidth-1:0] dyn_addr;
  logic sta_valid;
  logic dyn_valid;
  logic bus_start;
  logic bus_rstart;
  logic bus_stop;
  logic parity_err;
  logic rx_full;
  logic rx_wvalid;
  logic [ByteWidth-1:0] rx_wdata;
  logic desc_wvalid;
  logic [DescWidth-1:0] desc_wdata;

  logic [ByteWidth-1:0] exp_bytes[$];
  logic [DescWidth-1:0] exp_descs[$];
  int unsigned exp_events[$];
  int unsigned obs_events[$];
  int unsigned exp_parity;
  int unsigned obs_parity;
  int unsigned err_count;
  int unsigned errs_at_start;
  int unsigned tests_run;
  int unsigned tests_failed;
  string cur_name;

  // Open drain, the target can only pull SDA low
  assign sda_bus = sda_drv & sda_dut;

  controller_standby_i3c #(
    .SyncStages (2),
    .RxDescWidth(DescWidth)
  ) i_dut (
    .clk_i                  (clk_i),
    .rst_ni                 (rst_ni),
    .i3c_standby_en_i       (standby_en),
    .ctrl_scl_i             (scl),
    .ctrl_sda_i             (sda_bus),
    .ctrl_sda_o             (sda_dut),
    .target_sta_addr_i      (sta_addr),
    .target_dyn_addr_i      (dyn_addr),
    .target_sta_addr_valid_i(sta_valid),
    .target_dyn_addr_valid_i(dyn_valid),
    .bus_start_o            (bus_start),
    .bus_rstart_o           (bus_rstart),
    .bus_stop_o             (bus_stop),
    .parity_err_o           (parity_err),
    .rx_queue_full_i        (rx_full),
    .rx_queue_wvalid_o      (rx_wvalid),
    .rx_queue_wdata_o       (rx_wdata),
    .rx_desc_queue_wvalid_o (desc_wvalid),
    .rx_desc_queue_wdata_o  (desc_wdata)
  );

  initial begin
    clk_i = 1'b0;
    forever #(ClkPeriod / 2) clk_i = ~clk_i;
  end

  initial begin
    #(WatchdogNs);
    $display("Timeout, the run did not finish within %0d ns", WatchdogNs);
    $display("TESTBENCH FAILED");
    $finish;
  end

  task automatic compare(input string what, input logic [31:0] expected,
                         input logic [31:0] actual);
    if (expected !== actual) begin
      $display("Fail %s: expected %h, actual %h", what, expected, actual);
      err_count++;
    end
  endtask

  // Bus strobes and queue writes against the model
  always @(posedge clk_i) begin
    if (bus_start) obs_events.push_back(EvStart);
    if (bus_rstart) obs_events.push_back(EvRstart);
    if (bus_stop) obs_events.push_back(EvStop);
    if (parity_err) obs_parity++;
    if (rx_wvalid) begin
      if (exp_bytes.size() == 0) begin
        $display("%s: unexpected RX queue write of %h", cur_name, rx_wdata);
        err_count++;
      end else begin
        compare({cur_name, " data byte"}, exp_bytes.pop_front(), rx_wdata);
      end
    end
    if (desc_wvalid) begin
      if (exp_descs.size() == 0) begin
        $display("%s: unexpected descriptor write of %h", cur_name, desc_wdata);
        err_count++;
      end else begin
        compare({cur_name, " descriptor"}, exp_descs.pop_front(), desc_wdata);
      end
    end
  end

  task automatic wait_clk(input int unsigned n);
    repeat (n) @(posedge clk_i);
    #2;
  endtask

  task automatic drive_bit(input logic b, output logic sampled);
    scl = 1'b0;
    wait_clk(2);
    sda_drv = b;
    wait_clk(HalfScl - 2);
    scl = 1'b1;
    wait_clk(HalfScl - 1);
    sampled = sda_bus;
    wait_clk(1);
  endtask

  // MSB first, the ninth bit reads back as the ACK
  task automatic drive_byte(input logic [7:0] data, input logic ninth, output logic sampled);
    logic unused;
    for (int i = ByteWidth - 1; i >= 0; i--) begin
      drive_bit(data[i], unused);
    end
    drive_bit(ninth, sampled);
  endtask

  task automatic drive_start();
    sda_drv = 1'b0;
    exp_events.push_back(EvStart);
    wait_clk(HalfScl);
  endtask

  task automatic drive_rstart();
    scl = 1'b0;
    wait_clk(2);
    sda_drv = 1'b1;
    wait_clk(HalfScl - 2);
    scl = 1'b1;
    wait_clk(HalfScl);
    sda_drv = 1'b0;
    exp_events.push_back(EvRstart);
    wait_clk(HalfScl);
  endtask

  task automatic drive_stop();
    scl = 1'b0;
    wait_clk(2);
    sda_drv = 1'b0;
    wait_clk(HalfScl - 2);
    scl = 1'b1;
    wait_clk(HalfScl);
    sda_drv = 1'b1;
    exp_events.push_back(EvStop);
    wait_clk(HalfScl);
  endtask

  task automatic do_xfer(input logic [7:0] addr_raw, input bit match, input int unsigned nbytes,
                         input bit bad_par, input bit use_full);
    logic ack;
    logic [7:0] data;
    bit bad;
    bit full;
    bit overflow;
    bit par_seen;
    int unsigned written;
    overflow = 1'b0;
    par_seen = 1'b0;
    written = 0;
    drive_byte(addr_raw, 1'b1, ack);
    compare({cur_name, " ack"}, match ? 0 : 1, ack);
    for (int unsigned i = 0; i < nbytes; i++) begin
      data = 8'($urandom);
      // Fault forced on one early byte so every such transfer shows it
      bad = bad_par && (i == 0 || $urandom_range(1) == 1);
      full = use_full && (i == 1 || $urandom_range(1) == 1);
      rx_full = full;
      if (match && full) begin
        overflow = 1'b1;
      end else if (match) begin
        exp_bytes.push_back(data);
        written++;
      end
      if (match && bad) begin
        par_seen = 1'b1;
        exp_parity++;
      end
      // T-bit makes the count of ones odd
      drive_byte(data, ~^data ^ bad, ack);
    end
    rx_full = 1'b0;
    if (match) exp_descs.push_back({addr_raw, 6'b0, par_seen, overflow, 16'(written)});
  endtask

  task automatic write_once(input logic [7:0] addr_raw, input bit match, input bit bad_par,
                            input bit use_full);
    drive_start();
    do_xfer(addr_raw, match, $urandom_range(MaxBytes, 2), bad_par, use_full);
    drive_stop();
  endtask

  task automatic begin_test(input string name);
    cur_name = name;
    errs_at_start = err_count;
    exp_parity = 0;
    obs_parity = 0;
    exp_events.delete();
    obs_events.delete();
  endtask

  task automatic end_test();
    int unsigned n;
    n = 0;
    while ((exp_bytes.size() != 0 || exp_descs.size() != 0) && n < 4 * HalfScl) begin
      wait_clk(1);
      n++;
    end
    if (exp_bytes.size() != 0 || exp_descs.size() != 0) begin
      $display("%s: %0d data bytes and %0d descriptors were never written", cur_name,
               exp_bytes.size(), exp_descs.size());
      err_count++;
      exp_bytes.delete();
      exp_descs.delete();
    end
    compare({cur_name, " parity pulses"}, exp_parity, obs_parity);
    tests_run++;
    if (err_count != errs_at_start) begin
      tests_failed++;
      $display("Test %s: failed with %0d errors", cur_name, err_count - errs_at_start);
    end else begin
      $display("Test %s: ok", cur_name);
    end
  endtask

  initial begin
    void'($urandom(32'h5eaf_5070));
    err_count = 0;
    tests_run = 0;
    tests_failed = 0;
    rst_ni = 1'b0;
    standby_en = 1'b1;
    scl = 1'b1;
    sda_drv = 1'b1;
    rx_full = 1'b0;
    dyn_addr = 7'($urandom_range(7'h3f, 7'h08));
    sta_addr = dyn_addr ^ 7'($urandom_range(7'h3f, 7'h01));
    dyn_valid = 1'b1;
    sta_valid = 1'b1;
    repeat (5) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    wait_clk(4);

    begin_test("bus_conditions");
    for (int r = 0; r < 3; r++) begin
      drive_start();
      repeat ($urandom_range(2)) drive_rstart();
      drive_stop();
    end
    compare({cur_name, " count"}, exp_events.size(), obs_events.size());
    while (exp_events.size() != 0 && obs_events.size() != 0) begin
      compare({cur_name, " order"}, exp_events.pop_front(), obs_events.pop_front());
    end
    end_test();

    begin_test("matching_write");
    repeat (3) write_once({dyn_addr, 1'b0}, 1'b1, 1'b0, 1'b0);
    // Static address answers only while no dynamic one is valid
    dyn_valid = 1'b0;
    write_once({sta_addr, 1'b0}, 1'b1, 1'b0, 1'b0);
    dyn_valid = 1'b1;
    end_test();

    begin_test("no_match");
    write_once({dyn_addr ^ 7'h40, 1'b0}, 1'b0, 1'b0, 1'b0);
    write_once({dyn_addr, 1'b1}, 1'b0, 1'b0, 1'b0);
    write_once({sta_addr, 1'b0}, 1'b0, 1'b0, 1'b0);
    end_test();

    begin_test("parity");
    repeat (3) write_once({dyn_addr, 1'b0}, 1'b1, 1'b1, 1'b0);
    end_test();

    begin_test("back_pressure");
    repeat (3) write_once({dyn_addr, 1'b0}, 1'b1, 1'b0, 1'b1);
    end_test();

    begin_test("rstart_split");
    drive_start();
    do_xfer({dyn_addr, 1'b0}, 1'b1, $urandom_range(3, 1), 1'b0, 1'b0);
    drive_rstart();
    do_xfer({dyn_addr, 1'b0}, 1'b1, $urandom_range(MaxBytes, 4), 1'b0, 1'b0);
    drive_stop();
    end_test();

    if (i_dut.i_assert.fail_count != 0) begin
      $display("%0d bound assertion failures", i_dut.i_assert.fail_count);
      err_count += i_dut.i_assert.fail_count;
    end
    $display("Tests run: %0d, failed: %0d, errors: %0d", tests_run, tests_failed, err_count);
    if (err_count == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* verilog/bus_rx_flow.sv */
// Bus RX flow, shifts SDA in on SCL rising edges and reports bytes and single bits
`timescale 1ns/10ps

module bus_rx_flow (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            scl_posedge_i,
  input  logic                            sda_i,
  input  logic                            restart_i,
  input  logic                            req_byte_i,
  input  logic                            req_bit_i,
  output logic [i3c_rx_pkg::ByteWidth-1:0] data_o,
  output logic                            done_o
);
  import i3c_rx_pkg::*;

  localparam int unsigned CntWidth = $clog2(ByteWidth);
  localparam logic [CntWidth-1:0] LastBit = CntWidth'(ByteWidth - 1);

  logic [ByteWidth-1:0] shift_q;
  logic [CntWidth-1:0] bit_cnt;
  logic req_active;
  logic last_bit;

  assign req_active = req_byte_i | req_bit_i;

  // A bit request completes on its first sample
  assign last_bit = req_bit_i | (bit_cnt == LastBit);

  // MSB first, the current sample lands in bit 0
  assign data_o = {shift_q[ByteWidth-2:0], sda_i};
  assign done_o = scl_posedge_i & req_active & last_bit;

  always_ff @(posedge clk_i) begin
    if (scl_posedge_i) begin
      shift_q <= data_o;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_cnt <= '0;
    end else if (restart_i || !req_active || done_o) begin
      bit_cnt <= '0;
    end else if (scl_posedge_i) begin
      bit_cnt <= bit_cnt + 1'b1;
    end
  end

endmodule

/* verilog/controller_standby_i3c.sv */
// I3C standby target receive path, top level
`timescale 1ns/10ps

module controller_standby_i3c #(
  parameter int unsigned SyncStages  = 2,
  parameter int unsigned RxDescWidth = i3c_rx_pkg::DescWidth
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            i3c_standby_en_i,
  input  logic                            ctrl_scl_i,
  input  logic                            ctrl_sda_i,
  output logic                            ctrl_sda_o,
  input  logic [i3c_rx_pkg::AddrWidth-1:0] target_sta_addr_i,
  input  logic [i3c_rx_pkg::AddrWidth-1:0] target_dyn_addr_i,
  input  logic                            target_sta_addr_valid_i,
  input  logic                            target_dyn_addr_valid_i,
  output logic                            bus_start_o,
  output logic                            bus_rstart_o,
  output logic                            bus_stop_o,
  output logic                            parity_err_o,
  input  logic                            rx_queue_full_i,
  output logic                            rx_queue_wvalid_o,
  output logic [i3c_rx_pkg::ByteWidth-1:0] rx_queue_wdata_o,
  output logic                            rx_desc_queue_wvalid_o,
  output logic [RxDescWidth-1:0]          rx_desc_queue_wdata_o
);
  import i3c_rx_pkg::*;

  logic scl_posedge;
  logic scl_negedge;
  logic sda_sync;
  logic bus_restart;
  logic rx_req_byte;
  logic rx_req_bit;
  logic rx_done;
  logic [ByteWidth-1:0] rx_data;
  logic xfer_begin;
  addr_byte_u addr_byte;
  logic byte_valid;
  logic [ByteWidth-1:0] rx_byte;
  logic xfer_end;

  assign bus_restart = bus_start_o | bus_rstart_o;

  bus_monitor #(
    .SyncStages(SyncStages)
  ) xbus_monitor (
    .clk_i,
    .rst_ni,
    .enable_i     (i3c_standby_en_i),
    .scl_i        (ctrl_scl_i),
    .sda_i        (ctrl_sda_i),
    .scl_posedge_o(scl_posedge),
    .scl_negedge_o(scl_negedge),
    .sda_o        (sda_sync),
    .start_o      (bus_start_o),
    .rstart_o     (bus_rstart_o),
    .stop_o       (bus_stop_o)
  );

  bus_rx_flow xbus_rx_flow (
    .clk_i,
    .rst_ni,
    .scl_posedge_i(scl_posedge),
    .sda_i        (sda_sync),
    .restart_i    (bus_restart),
    .req_byte_i   (rx_req_byte),
    .req_bit_i    (rx_req_bit),
    .data_o       (rx_data),
    .done_o       (rx_done)
  );

  target_rx_fsm xtarget_rx_fsm (
    .clk_i,
    .rst_ni,
    .enable_i        (i3c_standby_en_i),
    .start_i         (bus_start_o),
    .rstart_i        (bus_rstart_o),
    .stop_i          (bus_stop_o),
    .scl_negedge_i   (scl_negedge),
    .rx_done_i       (rx_done),
    .rx_data_i       (rx_data),
    .rx_req_byte_o   (rx_req_byte),
    .rx_req_bit_o    (rx_req_bit),
    .sta_addr_i      (target_sta_addr_i),
    .dyn_addr_i      (target_dyn_addr_i),
    .sta_addr_valid_i(target_sta_addr_valid_i),
    .dyn_addr_valid_i(target_dyn_addr_valid_i),
    .sda_o           (ctrl_sda_o),
    .xfer_begin_o    (xfer_begin),
    .addr_byte_o     (addr_byte),
    .byte_valid_o    (byte_valid),
    .byte_o          (rx_byte),
    .xfer_end_o      (xfer_end),
    .parity_err_o    (parity_err_o)
  );

  descriptor_rx #(
    .RxDescWidth(RxDescWidth)
  ) xdescriptor_rx (
    .clk_i,
    .rst_ni,
    .xfer_begin_i          (xfer_begin),
    .addr_byte_i           (addr_byte),
    .byte_valid_i          (byte_valid),
    .byte_i                (rx_byte),
    .parity_err_i          (parity_err_o),
    .xfer_end_i            (xfer_end),
    .rx_queue_full_i       (rx_queue_full_i),
    .rx_queue_wvalid_o     (rx_queue_wvalid_o),
    .rx_queue_wdata_o      (rx_queue_wdata_o),
    .rx_desc_queue_wvalid_o(rx_desc_queue_wvalid_o),
    .rx_desc_queue_wdata_o (rx_desc_queue_wdata_o)
  );

endmodule

/* verilog/descriptor_rx.sv */
// RX descriptor writer, pushes data bytes and one closing descriptor per write
`timescale 1ns/10ps

module descriptor_rx #(
  parameter int unsigned RxDescWidth = i3c_rx_pkg::DescWidth
) (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            xfer_begin_i,
  input  i3c_rx_pkg::addr_byte_u          addr_byte_i,
  input  logic                            byte_valid_i,
  input  logic [i3c_rx_pkg::ByteWidth-1:0] byte_i,
  input  logic                            parity_err_i,
  input  logic                            xfer_end_i,
  input  logic                            rx_queue_full_i,
  output logic                            rx_queue_wvalid_o,
  output logic [i3c_rx_pkg::ByteWidth-1:0] rx_queue_wdata_o,
  output logic                            rx_desc_queue_wvalid_o,
  output logic [RxDescWidth-1:0]          rx_desc_queue_wdata_o
);
  import i3c_rx_pkg::*;

  logic [ByteWidth-1:0] addr_raw_q;
  logic [CountWidth-1:0] byte_cnt_q;
  logic overflow_q;
  logic parity_q;
  logic [DescWidth-1:0] desc_word;

  always_comb begin
    desc_word                   = '0;
    desc_word[31:24]            = addr_raw_q;
    desc_word[17]               = parity_q;
    desc_word[16]               = overflow_q;
    desc_word[CountWidth-1:0]   = byte_cnt_q;
  end

  always_ff @(posedge clk_i) begin
    if (xfer_begin_i) begin
      addr_raw_q <= addr_byte_i.raw;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rx_queue_wvalid_o      <= 1'b0;
      rx_queue_wdata_o       <= '0;
      rx_desc_queue_wvalid_o <= 1'b0;
      rx_desc_queue_wdata_o  <= '0;
      byte_cnt_q             <= '0;
      overflow_q             <= 1'b0;
      parity_q               <= 1'b0;
    end else begin
      rx_queue_wvalid_o      <= 1'b0;
      rx_desc_queue_wvalid_o <= 1'b0;
      if (byte_valid_i) begin
        // A full queue drops the byte and marks the transfer
        if (!rx_queue_full_i) begin
          rx_queue_wvalid_o <= 1'b1;
          rx_queue_wdata_o  <= byte_i;
          byte_cnt_q        <= byte_cnt_q + 1'b1;
        end else begin
          overflow_q <= 1'b1;
        end
      end
      if (parity_err_i) begin
        parity_q <= 1'b1;
      end
      if (xfer_end_i) begin
        rx_desc_queue_wvalid_o <= 1'b1;
        rx_desc_queue_wdata_o  <= RxDescWidth'(desc_word);
      end
      if (xfer_end_i || xfer_begin_i) begin
        byte_cnt_q <= '0;
        overflow_q <= 1'b0;
        parity_q   <= 1'b0;
      end
    end
  end

endmodule

/* verilog/target_rx_fsm.sv */
// Target RX FSM, matches the address, drives the ACK and checks data T-bits
`timescale 1ns/10ps

module target_rx_fsm (
  input  logic                            clk_i,
  input  logic                            rst_ni,
  input  logic                            enable_i,
  input  logic                            start_i,
  input  logic                            rstart_i,
  input  logic                            stop_i,
  input  logic                            scl_negedge_i,
  input  logic                            rx_done_i,
  input  logic [i3c_rx_pkg::ByteWidth-1:0] rx_data_i,
  output logic                            rx_req_byte_o,
  output logic                            rx_req_bit_o,
  input  logic [i3c_rx_pkg::AddrWidth-1:0] sta_addr_i,
  input  logic [i3c_rx_pkg::AddrWidth-1:0] dyn_addr_i,
  input  logic                            sta_addr_valid_i,
  input  logic                            dyn_addr_valid_i,
  output logic                            sda_o,
  output logic                            xfer_begin_o,
  output i3c_rx_pkg::addr_byte_u          addr_byte_o,
  output logic                            byte_valid_o,
  output logic [i3c_rx_pkg::ByteWidth-1:0] byte_o,
  output logic                            xfer_end_o,
  output logic                            parity_err_o
);
  import i3c_rx_pkg::*;

  rx_state_e state_q;
  addr_byte_u rx_addr;
  logic [ByteWidth-1:0] data_q;
  logic addr_match;
  logic tbit_ok;
  logic in_write;

  assign rx_addr.raw = rx_data_i;

  // Dynamic address takes over once assigned; reads are never acknowledged
  assign addr_match = ~rx_addr.fields.rnw &
                      (dyn_addr_valid_i ? (rx_addr.fields.addr == dyn_addr_i)
                                        : (sta_addr_valid_i &
                                           (rx_addr.fields.addr == sta_addr_i)));

  // Odd parity over the data byte and its T-bit
  assign tbit_ok = ^{data_q, rx_data_i[0]};

  assign in_write = (state_q == Data) || (state_q == TBit);

  assign rx_req_byte_o = (state_q == Addr) || (state_q == Data);
  assign rx_req_bit_o  = (state_q == TBit);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= Idle;
      sda_o        <= 1'b1;
      xfer_begin_o <= 1'b0;
      byte_valid_o <= 1'b0;
      xfer_end_o   <= 1'b0;
      parity_err_o <= 1'b0;
    end else begin
      xfer_begin_o <= 1'b0;
      byte_valid_o <= 1'b0;
      xfer_end_o   <= 1'b0;
      parity_err_o <= 1'b0;
      if (!enable_i) begin
        state_q <= Idle;
        sda_o   <= 1'b1;
      end else if (start_i || rstart_i || stop_i) begin
        xfer_end_o <= (rstart_i | stop_i) & in_write;
        state_q    <= stop_i ? Idle : Addr;
        sda_o      <= 1'b1;
      end else begin
        unique case (state_q)
          Addr: begin
            if (rx_done_i) begin
              state_q <= addr_match ? AddrAck : Ignore;
            end
          end
          AddrAck: begin
            // First falling edge pulls SDA low, the second one releases it
            if (scl_negedge_i) begin
              if (sda_o) begin
                sda_o        <= 1'b0;
                xfer_begin_o <= 1'b1;
              end else begin
                sda_o   <= 1'b1;
                state_q <= Data;
              end
            end
          end
          Data: begin
            if (rx_done_i) begin
              state_q <= TBit;
            end
          end
          TBit: begin
            if (rx_done_i) begin
              byte_valid_o <= 1'b1;
              parity_err_o <= ~tbit_ok;
              state_q      <= Data;
            end
          end
          default: begin
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (rx_done_i) begin
      if (state_q == Addr) begin
        addr_byte_o <= rx_addr;
      end
      if (state_q == Data) begin
        data_q <= rx_data_i;
      end
      if (state_q == TBit) begin
        byte_o <= data_q;
      end
    end
  end

endmodule
